/* Bender.yml */
package:
  name: rrag

sources:
  - include_dirs:
      - logic
    files:
      - logic/arch_state_pkg.sv
      - logic/uop_pkg.sv
      - logic/gpr_file.sv
      - logic/seg_file.sv
      - logic/addr_gen.sv
      - logic/issue_sequencer.sv
      - logic/rrag_stage.sv
  - target: test
    files:
      - tb/rrag_properties.sv
      - tb/rrag_tb.sv

/* logic/addr_gen.sv */
`timescale 1ns/10ps

module addr_gen import arch_state_pkg::*, uop_pkg::*; (
    input  uop_t      uop,
    input  word_t     base,
    input  word_t     index,
    input  word_t     reg4,
    input  selector_t seg1,
    input  selector_t seg2,
    output addr_t     mem_addr1,
    output addr_t     mem_addr1_end,
    output addr_t     mem_addr2,
    output addr_t     mem_addr2_end
);

    addr_t base_term;
    addr_t index_term;
    addr_t seg1_term;
    addr_t seg2_term;
    addr_t size_m1;

    assign base_term  = uop.use_base ? addr_t'(base) : '0;
    assign index_term = uop.use_index ? (addr_t'(index) << uop.scale) : '0;

    // Selector used directly as the upper half of the base
    assign seg1_term = addr_t'({seg1, 16'h0000});
    assign seg2_term = addr_t'({seg2, 16'h0000});

    assign mem_addr1 = base_term + index_term + uop.disp + seg1_term;
    assign mem_addr2 = addr_t'(reg4) + seg2_term;

    // Last byte touched, wraps at 4 GB
    assign size_m1       = (addr_t'(1) << uop.opsize) - addr_t'(1);
    assign mem_addr1_end = mem_addr1 + size_m1;
    assign mem_addr2_end = mem_addr2 + size_m1;

endmodule

/* logic/arch_state_pkg.sv */
`include "rrag_config.svh"

package arch_state_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] selector_t;

    // One general register load from writeback
    typedef struct packed {
        logic                              ld;
        logic [$clog2(`RRAG_NUM_GPR)-1:0]  addr;
        logic [1:0]                        size;    // Same coding as op_size_t
        word_t                             data;
    } gpr_wb_t;

    // One segment selector load from writeback
    typedef struct packed {
        logic                              ld;
        logic [$clog2(`RRAG_NUM_GPR)-1:0]  addr;    // 6 and 7 are not segments
        selector_t                         sel;
    } seg_wb_t;

endpackage

/* logic/gpr_file.sv */
`timescale 1ns/10ps
`include "rrag_config.svh"

module gpr_file import arch_state_pkg::*, uop_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  gpr_wb_t                  wb,
    input  reg_idx_t [3:0]           rd_addr,
    input  logic                     set_pending,
    input  logic [`RRAG_NUM_GPR-1:0] dest_mask,
    output word_t [3:0]              rd_data,
    output logic [3:0]               rd_pending
);

    word_t                    regs [`RRAG_NUM_GPR];
    logic [`RRAG_NUM_GPR-1:0] pending;
    logic [`RRAG_NUM_GPR-1:0] clr_mask;
    word_t                    wb_merged;

    // Narrow loads keep the upper bytes
    always_comb begin
        wb_merged = wb.data;
        case (wb.size)
            OP_SIZE_1: wb_merged = {regs[wb.addr][31:8], wb.data[7:0]};
            OP_SIZE_2: wb_merged = {regs[wb.addr][31:16], wb.data[15:0]};
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RRAG_NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.ld) begin
            regs[wb.addr] <= wb_merged;
        end
    end

    assign clr_mask = wb.ld ? (`RRAG_NUM_GPR'(1) << wb.addr) : '0;

    // A new destination wins over a same-cycle writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | (set_pending ? dest_mask : '0);
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rd_data[p]    = regs[rd_addr[p]];
            rd_pending[p] = pending[rd_addr[p]];
        end
    end

endmodule

/* logic/issue_sequencer.sv */
`timescale 1ns/10ps

module issue_sequencer import arch_state_pkg::*, uop_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid_in,
    input  logic        fwd_stall,
    input  uop_t        uop,
    input  word_t [3:0] rd_data,
    input  logic [3:0]  rd_pending,
    input  addr_t       mem_addr1,
    input  addr_t       mem_addr1_end,
    input  addr_t       mem_addr2,
    input  addr_t       mem_addr2_end,
    output logic        stall,
    output logic        valid_out,
    output logic        set_pending,
    output issue_t      issue
);

    rep_state_t state;
    word_t      remaining;  // Iterations left, current one included
    addr_t      offset;
    addr_t      step;
    word_t      count_mask;
    word_t      rep_count;
    logic       src_pending;
    logic       hold;
    logic       go;
    logic       rep_more;
    logic       fire;

    always_comb begin
        case (uop.opsize)
            OP_SIZE_1: count_mask = 32'h0000_00FF;
            OP_SIZE_2: count_mask = 32'h0000_FFFF;
            default:   count_mask = 32'hFFFF_FFFF;
        endcase
    end

    assign rep_count = rd_data[2] & count_mask;  // Count lives in register 3
    assign step      = addr_t'(1) << uop.opsize;

    assign src_pending = (uop.mem1_use && uop.use_base && rd_pending[1])
                      || (uop.mem1_use && uop.use_index && rd_pending[2])
                      || (uop.mem2_use && rd_pending[3]);

    assign hold = valid_in && (fwd_stall || src_pending);
    assign go   = valid_in && !hold;

    assign rep_more = (state == ITER) ? (remaining > 32'd1)
                                      : (valid_in && uop.is_rep && rep_count > 32'd1);

    // Zero count REP is consumed silently
    assign fire = go && (state == ITER || !uop.is_rep || rep_count != '0);

    assign stall       = hold || rep_more;
    assign set_pending = fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            remaining <= '0;
            offset    <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= fire;
            if (go) begin
                case (state)
                    IDLE: begin
                        if (uop.is_rep && rep_count > 32'd1) begin
                            state     <= ITER;
                            remaining <= rep_count - 32'd1;
                            offset    <= step;
                        end
                    end
                    ITER: begin
                        if (remaining > 32'd1) begin
                            remaining <= remaining - 32'd1;
                            offset    <= offset + step;
                        end else begin
                            state     <= IDLE;
                            remaining <= '0;
                            offset    <= '0;  // Next micro-op starts at zero
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            issue.tag           <= uop.tag;
            issue.opsize        <= uop.opsize;
            issue.mem_addr1     <= mem_addr1 + offset;
            issue.mem_addr1_end <= mem_addr1_end + offset;
            issue.mem_addr2     <= mem_addr2 + offset;
            issue.mem_addr2_end <= mem_addr2_end + offset;
            issue.reg_data      <= rd_data;
        end
    end

endmodule

/* logic/rrag_config.svh */
`ifndef RRAG_CONFIG_SVH
`define RRAG_CONFIG_SVH

// General registers EAX..EDI
`define RRAG_NUM_GPR 8

// ES, CS, SS, DS, FS, GS
`define RRAG_NUM_SEG 6

// Linear address width
`define RRAG_ADDR_W 32

// Every segment reports this limit out of reset
`define RRAG_SEG_LIMIT 20'hF_FFFF

`endif

/* logic/rrag_stage.sv */
`timescale 1ns/10ps

module rrag_stage import arch_state_pkg::*, uop_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  uop_t    uop,
    input  logic    valid_in,
    input  logic    fwd_stall,
    input  gpr_wb_t gpr_wb,
    input  seg_wb_t seg_wb,
    output logic    valid_out,
    output logic    stall,
    output issue_t  issue
);

    word_t [3:0]     rd_data;
    logic [3:0]      rd_pending;
    selector_t [1:0] rd_sel;
    addr_t           mem_addr1;
    addr_t           mem_addr1_end;
    addr_t           mem_addr2;
    addr_t           mem_addr2_end;
    logic            set_pending;

    gpr_file i_gpr_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb          (gpr_wb),
        .rd_addr     (uop.reg_addr),
        .set_pending (set_pending),
        .dest_mask   (uop.dest_mask),
        .rd_data     (rd_data),
        .rd_pending  (rd_pending)
    );

    seg_file i_seg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb      (seg_wb),
        .rd_addr (uop.seg_addr),
        .rd_sel  (rd_sel)
    );

    addr_gen i_addr_gen (
        .uop           (uop),
        .base          (rd_data[1]),
        .index         (rd_data[2]),
        .reg4          (rd_data[3]),
        .seg1          (rd_sel[0]),
        .seg2          (rd_sel[1]),
        .mem_addr1     (mem_addr1),
        .mem_addr1_end (mem_addr1_end),
        .mem_addr2     (mem_addr2),
        .mem_addr2_end (mem_addr2_end)
    );

    issue_sequencer i_issue_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_in      (valid_in),
        .fwd_stall     (fwd_stall),
        .uop           (uop),
        .rd_data       (rd_data),
        .rd_pending    (rd_pending),
        .mem_addr1     (mem_addr1),
        .mem_addr1_end (mem_addr1_end),
        .mem_addr2     (mem_addr2),
        .mem_addr2_end (mem_addr2_end),
        .stall         (stall),
        .valid_out     (valid_out),
        .set_pending   (set_pending),
        .issue         (issue)
    );

endmodule

/* logic/seg_file.sv */
`timescale 1ns/10ps
`include "rrag_config.svh"

module seg_file import arch_state_pkg::*, uop_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  seg_wb_t         wb,
    input  reg_idx_t [1:0]  rd_addr,
    output selector_t [1:0] rd_sel
);

    selector_t segs [`RRAG_NUM_SEG];
    logic      wb_hit;

    assign wb_hit = wb.ld && (wb.addr < `RRAG_NUM_SEG);  // Drop loads to 6 and 7

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RRAG_NUM_SEG; i++) begin
                segs[i] <= '0;
            end
        end else if (wb_hit) begin
            segs[wb.addr] <= wb.sel;
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (rd_addr[p] < `RRAG_NUM_SEG) begin
                rd_sel[p] = segs[rd_addr[p]];
            end else begin
                rd_sel[p] = '0;  // No such segment
            end
        end
    end

endmodule

/* logic/uop_pkg.sv */
`include "rrag_config.svh"

package uop_pkg;

    import arch_state_pkg::*;

    typedef logic [2:0] reg_idx_t;
    typedef logic [`RRAG_ADDR_W-1:0] addr_t;
    typedef logic [7:0] uop_tag_t;

    typedef enum logic [1:0] {
        OP_SIZE_1 = 2'd0,
        OP_SIZE_2 = 2'd1,
        OP_SIZE_4 = 2'd2,
        OP_SIZE_8 = 2'd3
    } op_size_t;

    typedef enum logic {
        IDLE,
        ITER
    } rep_state_t;

    // Index 0..3 are registers 1..4, register 2 is base, 3 is index
    typedef struct packed {
        uop_tag_t                 tag;
        op_size_t                 opsize;
        reg_idx_t [3:0]           reg_addr;
        reg_idx_t [1:0]           seg_addr;
        logic                     use_base;
        logic                     use_index;
        logic [1:0]               scale;
        addr_t                    disp;
        logic                     mem1_use;
        logic                     mem2_use;
        logic                     is_rep;
        logic [`RRAG_NUM_GPR-1:0] dest_mask;
    } uop_t;

    typedef struct packed {
        uop_tag_t    tag;
        op_size_t    opsize;
        addr_t       mem_addr1;
        addr_t       mem_addr1_end;
        addr_t       mem_addr2;
        addr_t       mem_addr2_end;
        word_t [3:0] reg_data;
    } issue_t;

endpackage

/* rrag.f */
+incdir+logic
logic/arch_state_pkg.sv
logic/uop_pkg.sv
logic/gpr_file.sv
logic/seg_file.sv
logic/addr_gen.sv
logic/issue_sequencer.sv
logic/rrag_stage.sv
tb/rrag_properties.sv
tb/rrag_tb.sv

/* tb/rrag_patterns.txt */
# W g|s num size data | E wait addr1 addr1_end addr2 addr2_end r1_value (all hex)
# I opsize r1 base index r4 s1 s2 use_base use_index scale disp mem1 mem2 rep dest fwd
W g 1 2 00001000
W g 2 2 00000040
W g 3 2 00000003
W g 4 2 00200000
W s 1 0 00000010
I 1 1 1 3 4 1 1 1 0 1 00000010 1 1 0 00 0
E 3 00101010 00101011 00300000 00300001 00001000
I 3 1 2 3 4 1 1 1 1 3 FFFFFFF0 1 1 0 00 0
E 3 00100048 0010004F 00300000 00300007 00001000
W g 5 2 12345678
W g 5 0 FFFFFFAB
I 0 5 1 3 4 1 1 1 1 0 00000000 1 1 0 00 0
E 3 00101003 00101003 00300000 00300000 123456AB
W g 5 1 FFFF9999
I 1 5 1 3 4 1 1 0 1 2 00000000 1 1 0 00 0
E 3 0010000C 0010000D 00300000 00300001 12349999
I 2 1 1 3 4 1 1 0 0 0 00000000 1 1 0 04 0
E 3 00100000 00100003 00300000 00300003 00001000
I 2 1 2 3 4 1 1 1 1 1 00000000 1 1 0 00 0
W g 2 2 00000400
E 4 00100406 00100409 00300000 00300003 00001000
I 2 1 1 3 4 1 1 1 0 0 00000000 1 1 0 00 2
W g 1 2 00002000
E 4 00102000 00102003 00300000 00300003 00002000
I 1 1 1 3 4 1 1 0 0 0 00000000 1 1 1 00 0
E 2 00100000 00100001 00300000 00300001 00002000
E 2 00100002 00100003 00300002 00300003 00002000
E 2 00100004 00100005 00300004 00300005 00002000
W g 7 2 00010002
I 1 1 1 0 4 1 1 0 0 0 00000100 1 1 1 00 0
I 1 1 1 7 4 1 1 0 0 0 00000200 1 1 1 00 0
E 3 00100200 00100201 00300000 00300001 00002000
E 2 00100202 00100203 00300002 00300003 00002000

/* tb/rrag_properties.sv */
`timescale 1ns/10ps

module rrag_properties import arch_state_pkg::*, uop_pkg::*; (
    input logic clk,
    input logic rst_n,
    input uop_t uop,
    input logic valid_in,
    input logic stall,
    input logic valid_out
);

    int   fail_count = 0;
    logic accept_single;

    assign accept_single = valid_in && !stall && !uop.is_rep;  // Taken, not a string op

    reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !valid_out)
        else begin
            fail_count++;
            $error("valid_out high in the first cycle after reset");
        end

    uop_held: assert property (@(posedge clk) disable iff (!rst_n)
        valid_in && stall |=> $stable(uop))
        else begin
            fail_count++;
            $error("uop changed while the stage was stalled");
        end

    single_issue: assert property (@(posedge clk) disable iff (!rst_n)
        accept_single |=> valid_out)
        else begin
            fail_count++;
            $error("no output one cycle after an accepted micro-op");
        end

endmodule

bind rrag_stage rrag_properties i_rrag_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .uop       (uop),
    .valid_in  (valid_in),
    .stall     (stall),
    .valid_out (valid_out)
);

/* tb/rrag_tb.sv */
`timescale 1ns/10ps

module rrag_tb import arch_state_pkg::*, uop_pkg::*; ();

    logic    clk = 1'b0;
    logic    rst_n;
    uop_t    uop;
    logic    valid_in;
    logic    fwd_stall;
    gpr_wb_t gpr_wb;
    seg_wb_t seg_wb;
    logic    valid_out;
    logic    stall;
    issue_t  issue;

    issue_t         out_q[$];       // Outputs seen but not yet checked
    logic [31:0]    fields [16];
    logic [15:0]    lfsr = 16'd14349;
    int             fd;
    int             fwd_left;
    int             value_errors;
    int             other_errors;
    int             limit_cycles;
    uop_tag_t       last_tag;
    op_size_t       last_size;
    reg_idx_t [3:0] last_rd_addr;
    word_t          gpr_model [8];  // Register contents after each writeback

    rrag_stage i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop       (uop),
        .valid_in  (valid_in),
        .fwd_stall (fwd_stall),
        .gpr_wb    (gpr_wb),
        .seg_wb    (seg_wb),
        .valid_out (valid_out),
        .stall     (stall),
        .issue     (issue)
    );

    always #5 clk = ~clk;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic read_fields(input int n);
        for (int i = 0; i < n; i++) begin
            void'($fscanf(fd, "%h", fields[i]));
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            value_errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // Sample at the falling edge and drive 1 ns after the rising edge
    task automatic tick();
        logic taken;
        @(negedge clk);
        taken = valid_in && !stall;
        if (valid_out) begin
            out_q.push_back(issue);
        end
        if (!valid_in || fwd_stall) begin
            check_word("stall", 32'(valid_in), 32'(stall));  // Idle or held upstream
        end
        @(posedge clk);
        #1;
        gpr_wb.ld = 1'b0;
        seg_wb.ld = 1'b0;
        if (taken) begin
            valid_in = 1'b0;
        end
        if (fwd_left > 0) begin
            fwd_left--;
        end
        fwd_stall = (fwd_left > 0);
    endtask

    task automatic apply_writeback(input string target);
        read_fields(3);
        if (target == "g") begin
            gpr_wb.ld   = 1'b1;
            gpr_wb.addr = fields[0][2:0];
            gpr_wb.size = fields[1][1:0];
            gpr_wb.data = fields[2];
        end else begin
            seg_wb.ld   = 1'b1;
            seg_wb.addr = fields[0][2:0];
            seg_wb.sel  = fields[2][15:0];
        end
        tick();
        // Narrow loads keep the upper bytes
        if (target == "g") begin
            case (fields[1][1:0])
                OP_SIZE_1: gpr_model[fields[0][2:0]][7:0]  = fields[2][7:0];
                OP_SIZE_2: gpr_model[fields[0][2:0]][15:0] = fields[2][15:0];
                default:   gpr_model[fields[0][2:0]]       = fields[2];
            endcase
        end
    endtask

    // Stays on the input until the stage takes it
    task automatic present_uop();
        logic [31:0] rnd;
        read_fields(16);
        random_bits(8, rnd);
        uop.tag    = rnd[7:0];
        uop.opsize = op_size_t'(fields[0][1:0]);
        for (int i = 0; i < 4; i++) begin
            uop.reg_addr[i] = fields[i + 1][2:0];
        end
        uop.seg_addr[0] = fields[5][2:0];
        uop.seg_addr[1] = fields[6][2:0];
        uop.use_base    = fields[7][0];
        uop.use_index   = fields[8][0];
        uop.scale       = fields[9][1:0];
        uop.disp        = fields[10];
        uop.mem1_use    = fields[11][0];
        uop.mem2_use    = fields[12][0];
        uop.is_rep      = fields[13][0];
        uop.dest_mask   = fields[14][7:0];
        fwd_left        = int'(fields[15]);
        fwd_stall       = (fwd_left > 0);
        valid_in        = 1'b1;
        last_tag        = uop.tag;
        last_size       = uop.opsize;
        last_rd_addr    = uop.reg_addr;
        tick();
    endtask

    task automatic expect_issue();
        int     waited;
        issue_t got;
        read_fields(6);
        waited = 0;
        while (out_q.size() == 0 && waited < int'(fields[0])) begin
            tick();
            waited++;
        end
        assert (out_q.size() != 0) else begin
            other_errors++;
            $display("No output arrived within %0d cycles at %0t", fields[0], $time);
        end
        if (out_q.size() != 0) begin
            got = out_q.pop_front();
            check_word("issue.tag", 32'(last_tag), 32'(got.tag));
            check_word("issue.opsize", 32'(last_size), 32'(got.opsize));
            check_word("issue.mem_addr1", fields[1], got.mem_addr1);
            check_word("issue.mem_addr1_end", fields[2], got.mem_addr1_end);
            check_word("issue.mem_addr2", fields[3], got.mem_addr2);
            check_word("issue.mem_addr2_end", fields[4], got.mem_addr2_end);
            check_word("issue.reg_data[0]", fields[5], got.reg_data[0]);
            for (int p = 1; p < 4; p++) begin
                check_word($sformatf("issue.reg_data[%0d]", p), gpr_model[last_rd_addr[p]],
                           got.reg_data[p]);
            end
        end
    endtask

    initial begin
        int    lines;
        string kind;
        string target;
        string line;
        rst_n        = 1'b0;
        uop          = '0;
        valid_in     = 1'b0;
        fwd_stall    = 1'b0;
        gpr_wb       = '0;
        seg_wb       = '0;
        fwd_left     = 0;
        value_errors = 0;
        other_errors = 0;
        lines        = 0;
        last_rd_addr = '0;
        for (int r = 0; r < 8; r++) begin
            gpr_model[r] = '0;  // Registers clear on reset
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fd = $fopen("tb/rrag_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open tb/rrag_patterns.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
            limit_cycles = lines * 20;
            fd = $fopen("tb/rrag_patterns.txt", "r");
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    void'($fgets(line, fd));
                end else if (kind == "W") begin
                    void'($fscanf(fd, "%s", target));
                    apply_writeback(target);
                end else if (kind == "I") begin
                    present_uop();
                end else if (kind == "E") begin
                    expect_issue();
                end else begin
                    other_errors++;
                    $display("Unknown record kind %s in the pattern file", kind);
                end
            end
            $fclose(fd);
            repeat (4) tick();  // Catch stray outputs
        end
        assert (out_q.size() == 0) else begin
            other_errors++;
            $display("%0d outputs arrived that no pattern expected", out_q.size());
        end
        $display("Errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
                 i_dut.i_rrag_properties.fail_count);
        if (value_errors == 0 && other_errors == 0
            && i_dut.i_rrag_properties.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, errors: %0d value, %0d other", limit_cycles,
                 value_errors, other_errors);
        $display("tests failed");
        $finish;
    end

endmodule
